// File: src/mem_ctrl_params.svh
`ifndef MEM_CTRL_PARAMS_SVH
`define MEM_CTRL_PARAMS_SVH

// byte address into the RAM
`define MEM_ADDR_W 32

// data word and instruction width
`define MEM_DATA_W 32

// one RAM location
`define MEM_BYTE_W 8

// bytes per word and the index to pick one of them
`define MEM_LANES 4
`define MEM_LANE_IDX_W 2

`endif

// File: src/mem_ctrl_pkg.sv
`include "mem_ctrl_params.svh"

package mem_ctrl_pkg;

    // number of bytes in one access
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_e;

    // byte sequencer FSM
    typedef enum logic [1:0] {
        seq_idle  = 2'b00,
        seq_issue = 2'b01,
        seq_drain = 2'b10,
        seq_ack   = 2'b11
    } seq_state_e;

    // arbiter FSM, one state per granted client
    typedef enum logic [1:0] {
        arb_idle    = 2'b00,
        arb_lsb     = 2'b01,
        arb_icache  = 2'b10,
        arb_release = 2'b11
    } arb_state_e;

endpackage

// File: src/mem_access_if.sv
`timescale 1ns/10ps
`include "mem_ctrl_params.svh"

interface mem_access_if import mem_ctrl_pkg::*; ();

    // four-phase handshake
    logic req;
    logic ack;

    // request payload, steady while req is high
    logic                   write;
    logic [`MEM_ADDR_W-1:0] addr;
    access_size_e           size;
    logic [`MEM_DATA_W-1:0] wdata;

    // assembled load word, valid while ack is high
    logic [`MEM_DATA_W-1:0] rdata;

    modport master (
        output req,
        output write,
        output addr,
        output size,
        output wdata,
        input  ack,
        input  rdata
    );

    modport slave (
        input  req,
        input  write,
        input  addr,
        input  size,
        input  wdata,
        output ack
    );

endinterface

// File: src/mem_arbiter.sv
`timescale 1ns/10ps
`include "mem_ctrl_params.svh"

module mem_arbiter import mem_ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // load/store client
    input  logic                   lsb_req,
    input  logic                   lsb_write,
    input  logic [`MEM_ADDR_W-1:0] lsb_addr,
    input  access_size_e           lsb_size,
    input  logic [`MEM_DATA_W-1:0] lsb_wdata,
    output logic                   lsb_ack,
    output logic [`MEM_DATA_W-1:0] lsb_rdata,

    // instruction client
    input  logic                   icache_req,
    input  logic [`MEM_ADDR_W-1:0] icache_addr,
    output logic                   icache_ack,
    output logic [`MEM_DATA_W-1:0] icache_instr,

    // towards the byte sequencer
    mem_access_if.master           acc
);

    arb_state_e state;

    // copy the winning request while idle; it stays frozen once granted
    always_ff @(posedge clk) begin
        if (state == arb_idle) begin
            if (lsb_req) begin
                acc.write <= lsb_write;
                acc.addr  <= lsb_addr;
                acc.size  <= lsb_size;
                acc.wdata <= lsb_wdata;
            end else begin
                // fetches are always whole-word reads
                acc.write <= 1'b0;
                acc.addr  <= icache_addr;
                acc.size  <= size_word;
                acc.wdata <= '0;
            end
        end
    end

    // result registers, loaded as the internal ack arrives
    always_ff @(posedge clk) begin
        if (acc.req && acc.ack) begin
            if (state == arb_lsb) begin
                lsb_rdata <= acc.rdata;
            end
            if (state == arb_icache) begin
                icache_instr <= acc.rdata;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= arb_idle;
            acc.req    <= 1'b0;
            lsb_ack    <= 1'b0;
            icache_ack <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    // fixed priority, load/store first
                    if (lsb_req) begin
                        acc.req <= 1'b1;
                        state   <= arb_lsb;
                    end else if (icache_req) begin
                        acc.req <= 1'b1;
                        state   <= arb_icache;
                    end
                end
                arb_lsb: begin
                    if (acc.ack) begin
                        acc.req <= 1'b0;
                        lsb_ack <= 1'b1;
                        state   <= arb_release;
                    end
                end
                arb_icache: begin
                    if (acc.ack) begin
                        acc.req    <= 1'b0;
                        icache_ack <= 1'b1;
                        state      <= arb_release;
                    end
                end
                arb_release: begin
                    // wait for the served client to let go and the sequencer to settle
                    if (!(lsb_ack && lsb_req) && !(icache_ack && icache_req) && !acc.ack) begin
                        lsb_ack    <= 1'b0;
                        icache_ack <= 1'b0;
                        state      <= arb_idle;
                    end
                end
                default: begin
                    state <= arb_idle;
                end
            endcase
        end
    end

endmodule

// File: src/byte_sequencer.sv
`timescale 1ns/10ps
`include "mem_ctrl_params.svh"

module byte_sequencer import mem_ctrl_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,

    // one access from the arbiter
    mem_access_if.slave                acc,

    // byte-wide RAM port
    output logic                       mem_enable,
    output logic                       mem_write,
    output logic [`MEM_ADDR_W-1:0]     mem_addr,
    output logic [`MEM_BYTE_W-1:0]     mem_wdata,

    // towards the load assembler
    output logic                       capture,
    output logic [`MEM_LANE_IDX_W-1:0] lane
);

    // one extra bit so the counter can reach a full word
    localparam int CNT_W = `MEM_LANE_IDX_W + 1;

    seq_state_e                 state;
    logic [CNT_W-1:0]           count;
    logic [CNT_W-1:0]           total;
    logic [`MEM_LANE_IDX_W-1:0] issue_lane;
    logic [`MEM_LANE_IDX_W-1:0] next_lane;

    function automatic logic [CNT_W-1:0] byte_count(input access_size_e size);
        case (size)
            size_byte: byte_count = CNT_W'(1);
            size_half: byte_count = CNT_W'(2);
            default:   byte_count = CNT_W'(`MEM_LANES);
        endcase
    endfunction

    assign total     = byte_count(acc.size);
    assign next_lane = count[`MEM_LANE_IDX_W-1:0];

    // address, write byte and lane of the transfer going out next cycle
    always_ff @(posedge clk) begin
        if (state == seq_idle) begin
            mem_addr   <= acc.addr;
            mem_wdata  <= acc.wdata[`MEM_BYTE_W-1:0];
            issue_lane <= '0;
        end else if (state == seq_issue) begin
            mem_addr   <= acc.addr + `MEM_ADDR_W'(count);
            mem_wdata  <= acc.wdata[next_lane*`MEM_BYTE_W +: `MEM_BYTE_W];
            issue_lane <= next_lane;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= seq_idle;
            count      <= '0;
            mem_enable <= 1'b0;
            mem_write  <= 1'b0;
            acc.ack    <= 1'b0;
            capture    <= 1'b0;
            lane       <= '0;
        end else begin
            // read data shows up one cycle after the read was issued
            capture <= mem_enable && !mem_write;
            lane    <= issue_lane;

            case (state)
                seq_idle: begin
                    if (acc.req) begin
                        mem_enable <= 1'b1;
                        mem_write  <= acc.write;
                        count      <= CNT_W'(1);
                        state      <= seq_issue;
                    end
                end
                seq_issue: begin
                    if (count == total) begin
                        mem_enable <= 1'b0;
                        if (mem_write) begin
                            // stores are done once the last byte went out
                            acc.ack <= 1'b1;
                            state   <= seq_ack;
                        end else begin
                            state <= seq_drain;
                        end
                    end else begin
                        count <= count + CNT_W'(1);
                    end
                end
                seq_drain: begin
                    // last byte is being captured this cycle
                    acc.ack <= 1'b1;
                    state   <= seq_ack;
                end
                seq_ack: begin
                    if (!acc.req) begin
                        acc.ack <= 1'b0;
                        state   <= seq_idle;
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

endmodule

// File: src/load_assembler.sv
`timescale 1ns/10ps
`include "mem_ctrl_params.svh"

module load_assembler (
    input  logic                       clk,
    input  logic                       rst_n,

    // from the byte sequencer
    input  logic                       capture,
    input  logic [`MEM_LANE_IDX_W-1:0] lane,

    // RAM read byte
    input  logic [`MEM_BYTE_W-1:0]     mem_rdata,

    // assembled little-endian word
    output logic [`MEM_DATA_W-1:0]     word
);

    localparam int UPPER_W = `MEM_DATA_W - `MEM_BYTE_W;

    // lane 0 always comes first, so it also wipes the rest of the word.
    // shorter loads then end up zero-extended without knowing their size
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word <= '0;
        end else if (capture) begin
            if (lane == '0) begin
                word <= {{UPPER_W{1'b0}}, mem_rdata};
            end else begin
                word[lane*`MEM_BYTE_W +: `MEM_BYTE_W] <= mem_rdata;
            end
        end
    end

endmodule

// File: src/mem_ctrl.sv
`timescale 1ns/10ps
`include "mem_ctrl_params.svh"

module mem_ctrl import mem_ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // load/store client
    input  logic                   lsb_req,
    output logic                   lsb_ack,
    input  logic                   lsb_write,
    input  logic [`MEM_ADDR_W-1:0] lsb_addr,
    input  access_size_e           lsb_size,
    input  logic [`MEM_DATA_W-1:0] lsb_wdata,
    output logic [`MEM_DATA_W-1:0] lsb_rdata,

    // instruction client
    input  logic                   icache_req,
    output logic                   icache_ack,
    input  logic [`MEM_ADDR_W-1:0] icache_addr,
    output logic [`MEM_DATA_W-1:0] icache_instr,

    // byte-wide RAM
    output logic                   mem_enable,
    output logic                   mem_write,
    output logic [`MEM_ADDR_W-1:0] mem_addr,
    output logic [`MEM_BYTE_W-1:0] mem_wdata,
    input  logic [`MEM_BYTE_W-1:0] mem_rdata
);

    logic                       capture;
    logic [`MEM_LANE_IDX_W-1:0] lane;

    // granted access between arbiter and sequencer
    mem_access_if acc_if ();

    mem_arbiter u_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .lsb_req      (lsb_req),
        .lsb_write    (lsb_write),
        .lsb_addr     (lsb_addr),
        .lsb_size     (lsb_size),
        .lsb_wdata    (lsb_wdata),
        .lsb_ack      (lsb_ack),
        .lsb_rdata    (lsb_rdata),
        .icache_req   (icache_req),
        .icache_addr  (icache_addr),
        .icache_ack   (icache_ack),
        .icache_instr (icache_instr),
        .acc          (acc_if.master)
    );

    byte_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc        (acc_if.slave),
        .mem_enable (mem_enable),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .capture    (capture),
        .lane       (lane)
    );

    // assembled word feeds straight back into the access interface
    load_assembler u_assembler (
        .clk       (clk),
        .rst_n     (rst_n),
        .capture   (capture),
        .lane      (lane),
        .mem_rdata (mem_rdata),
        .word      (acc_if.rdata)
    );

endmodule

// File: tests/ram_model.sv
`timescale 1ns/10ps

module ram_model #(
    parameter int DEPTH = 512
) (
    input  logic        clk,
    input  logic        enable,
    input  logic        write,
    input  logic [31:0] addr,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata
);

    localparam int IDX_W = $clog2(DEPTH);

    // contents, preloaded by the testbench
    logic [7:0] mem [0:DEPTH-1];

    initial begin
        rdata = '0;
    end

    // registered read, data valid the cycle after the request
    always @(posedge clk) begin
        if (enable) begin
            if (write) begin
                mem[addr[IDX_W-1:0]] <= wdata;
            end else begin
                rdata <= mem[addr[IDX_W-1:0]];
            end
        end
    end

endmodule

// File: tests/mem_ctrl_tb.sv
`timescale 1ns/10ps

module mem_ctrl_tb import mem_ctrl_pkg::*; ();

    localparam int NUM_TXN   = 200;
    localparam int RAM_DEPTH = 512;
    // two clients at up to 20 cycles per transaction, plus slack
    localparam int TIMEOUT_CYCLES = 2 * NUM_TXN * 20 + 1000;

    logic         clk;
    logic         rst_n;
    logic         lsb_req;
    logic         lsb_ack;
    logic         lsb_write;
    logic [31:0]  lsb_addr;
    access_size_e lsb_size;
    logic [31:0]  lsb_wdata;
    logic [31:0]  lsb_rdata;
    logic         icache_req;
    logic         icache_ack;
    logic [31:0]  icache_addr;
    logic [31:0]  icache_instr;
    logic         mem_enable;
    logic         mem_write;
    logic [31:0]  mem_addr;
    logic [7:0]   mem_wdata;
    logic [7:0]   mem_rdata;

    // reference copy of the RAM
    logic [7:0]  model [0:RAM_DEPTH-1];
    logic [31:0] lsb_rnd [0:NUM_TXN-1];
    logic [31:0] lsb_data [0:NUM_TXN-1];
    logic [31:0] fetch_rnd [0:NUM_TXN-1];

    integer seed;
    int     err_cnt;
    int     tests_ok;
    int     tests_bad;
    int     cycle_cnt;
    int     same_start_cnt;

    // handshake monitor state
    logic prev_lsb_req;
    logic prev_lsb_ack;
    logic prev_ic_req;
    logic prev_ic_ack;
    logic lsb_served;
    logic ic_served;
    logic both_started;
    logic lsb_first;

    mem_ctrl mem_ctrl_i (.*);

    ram_model #(.DEPTH(RAM_DEPTH)) ram_i (
        .clk    (clk),
        .enable (mem_enable),
        .write  (mem_write),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .rdata  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // high address bits folded in so no two halves of the RAM look alike
    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 29) ^ 8'(a >> 5) ^ 8'h5a;
    endfunction

    function automatic int size_bytes(input access_size_e size);
        case (size)
            size_byte: return 1;
            size_half: return 2;
            default:   return 4;
        endcase
    endfunction

    // little-endian, zero above n bytes
    function automatic logic [31:0] model_word(input logic [31:0] addr, input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = model[addr + i];
        end
        return w;
    endfunction

    task automatic compare_values(input logic [31:0] expected, input logic [31:0] actual,
                                  input string msg);
        if (expected !== actual) begin
            $display("ERR %0t: %s, expected %h, got %h", $time, msg, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("test %s finished with %0d errors", name, err_cnt - errs_before);
    endtask

    task automatic lsb_access(input logic wr, input logic [31:0] addr,
                              input access_size_e size, input logic [31:0] wdata);
        int          n;
        logic [31:0] expected;
        n = size_bytes(size);
        expected = model_word(addr, n);
        @(posedge clk);
        #1;
        lsb_write = wr;
        lsb_addr  = addr;
        lsb_size  = size;
        lsb_wdata = wdata;
        lsb_req   = 1'b1;
        do @(negedge clk); while (!lsb_ack);
        if (wr) begin
            // store lands in the model as its ack rises
            for (int i = 0; i < n; i++) begin
                model[addr + i] = wdata[8*i +: 8];
            end
        end else begin
            compare_values(expected, lsb_rdata, $sformatf("load of %0d bytes at %h", n, addr));
        end
        @(posedge clk);
        #1;
        lsb_req = 1'b0;
        do @(negedge clk); while (lsb_ack);
    endtask

    task automatic fetch(input logic [31:0] addr);
        logic [31:0] expected;
        expected = model_word(addr, 4);
        @(posedge clk);
        #1;
        icache_addr = addr;
        icache_req  = 1'b1;
        do @(negedge clk); while (!icache_ack);
        compare_values(expected, icache_instr, $sformatf("fetch at %h", addr));
        @(posedge clk);
        #1;
        icache_req = 1'b0;
        do @(negedge clk); while (icache_ack);
    endtask

    task automatic watch_handshake(input string who, input logic req, input logic ack,
                                   input logic prev_req, input logic prev_ack,
                                   inout logic served);
        if (req && !prev_req) begin
            served = 1'b0;
        end
        if (ack && !prev_ack) begin
            compare_values(1, req, {who, " ack rose without req"});
            compare_values(0, served, {who, " ack rose twice for one req"});
            served = 1'b1;
        end
        if (!ack && prev_ack) begin
            compare_values(0, req, {who, " ack fell while req high"});
        end
        if (!req && !prev_req) begin
            compare_values(0, ack, {who, " ack still high after req dropped"});
        end
    endtask

    always @(negedge clk) begin
        // handshake rules apply once out of reset
        if (rst_n) begin
            watch_handshake("lsb", lsb_req, lsb_ack, prev_lsb_req, prev_lsb_ack, lsb_served);
            watch_handshake("fetch", icache_req, icache_ack, prev_ic_req, prev_ic_ack, ic_served);
            // both reqs new and no ack pending means the arbiter was idle
            if (lsb_req && icache_req && !prev_lsb_req && !prev_ic_req
                    && !lsb_ack && !icache_ack) begin
                both_started = 1'b1;
                lsb_first    = 1'b0;
                same_start_cnt++;
            end
            if (both_started && lsb_ack && !prev_lsb_ack) begin
                lsb_first = 1'b1;
            end
            if (both_started && icache_ack && !prev_ic_ack) begin
                compare_values(1, lsb_first, "fetch ack came before the load/store ack");
                both_started = 1'b0;
            end
            prev_lsb_req = lsb_req;
            prev_lsb_ack = lsb_ack;
            prev_ic_req  = icache_req;
            prev_ic_ack  = icache_ack;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the clients did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int errs;
        seed = 32'h62732302;
        err_cnt = 0;
        tests_ok = 0;
        tests_bad = 0;
        same_start_cnt = 0;
        prev_lsb_req = 1'b0;
        prev_lsb_ack = 1'b0;
        prev_ic_req = 1'b0;
        prev_ic_ack = 1'b0;
        lsb_served = 1'b0;
        ic_served = 1'b0;
        both_started = 1'b0;
        lsb_first = 1'b0;
        rst_n = 1'b0;
        lsb_req = 1'b0;
        lsb_write = 1'b0;
        lsb_addr = '0;
        lsb_size = size_byte;
        lsb_wdata = '0;
        icache_req = 1'b0;
        icache_addr = '0;
        for (int a = 0; a < RAM_DEPTH; a++) begin
            model[a] = fill_byte(a);
            ram_i.mem[a] = fill_byte(a);
        end
        for (int k = 0; k < NUM_TXN; k++) begin
            lsb_rnd[k]   = $random(seed);
            lsb_data[k]  = $random(seed);
            fetch_rnd[k] = $random(seed);
        end

        errs = err_cnt;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (5) begin
            @(negedge clk);
            compare_values(0, lsb_ack, "lsb_ack after reset");
            compare_values(0, icache_ack, "icache_ack after reset");
            compare_values(0, mem_enable, "mem_enable after reset");
        end
        end_test("reset", errs);

        // overlapping stores of each size, then reads over them and next door
        errs = err_cnt;
        lsb_access(1'b1, 32'h100, size_word, 32'h1122_3344);
        lsb_access(1'b1, 32'h102, size_half, 32'h0000_beef);
        lsb_access(1'b1, 32'h101, size_byte, 32'h0000_00a5);
        lsb_access(1'b0, 32'h100, size_word, '0);
        lsb_access(1'b0, 32'h102, size_half, '0);
        lsb_access(1'b0, 32'h103, size_byte, '0);
        lsb_access(1'b0, 32'h104, size_word, '0);
        end_test("store_sizes", errs);

        errs = err_cnt;
        fetch(32'h000);
        fetch(32'h0fc);
        fetch(32'h040);
        end_test("fetch", errs);

        errs = err_cnt;
        fork
            lsb_access(1'b0, 32'h108, size_word, '0);
            fetch(32'h010);
        join
        compare_values(1, same_start_cnt > 0, "no same-cycle request pair seen");
        end_test("priority", errs);

        errs = err_cnt;
        fork
            begin : lsb_traffic
                access_size_e size;
                logic [31:0]  addr;
                for (int k = 0; k < NUM_TXN; k++) begin
                    repeat (lsb_rnd[k][2:0] % 6) @(posedge clk);
                    size = access_size_e'(lsb_rnd[k][4:3] % 2'd3);
                    addr = {23'h0, 1'b1, lsb_rnd[k][15:8]};
                    addr = addr & ~32'(size_bytes(size) - 1);
                    lsb_access(lsb_rnd[k][5], addr, size, lsb_data[k]);
                end
            end
            begin : fetch_traffic
                for (int k = 0; k < NUM_TXN; k++) begin
                    repeat (fetch_rnd[k][2:0] % 6) @(posedge clk);
                    fetch({24'h0, fetch_rnd[k][15:10], 2'b00});
                end
            end
        join
        for (int a = 0; a < RAM_DEPTH; a++) begin
            compare_values(model[a], ram_i.mem[a], $sformatf("ram byte at %h", a));
        end
        end_test("random_traffic", errs);

        $display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+src
src/mem_ctrl_pkg.sv
src/mem_access_if.sv
src/mem_arbiter.sv
src/byte_sequencer.sv
src/load_assembler.sv
src/mem_ctrl.sv
tests/ram_model.sv
tests/mem_ctrl_tb.sv
